//--- Bender.yml
package:
  name: eth_dma

sources:
  - verilog/eth_dma_bd_pkg.sv
  - verilog/eth_dma_axi_pkg.sv
  - verilog/eth_dma_bd_store.sv
  - verilog/eth_dma_bd_fetch.sv
  - verilog/eth_dma_tx_engine.sv
  - verilog/eth_dma_rx_engine.sv
  - verilog/eth_dma_status.sv
  - verilog/eth_dma.sv
  - target: test
    files:
      - tb/eth_dma_tb.sv

//--- eth_dma.f
verilog/eth_dma_bd_pkg.sv
verilog/eth_dma_axi_pkg.sv
verilog/eth_dma_bd_store.sv
verilog/eth_dma_bd_fetch.sv
verilog/eth_dma_tx_engine.sv
verilog/eth_dma_rx_engine.sv
verilog/eth_dma_status.sv
verilog/eth_dma.sv
tb/eth_dma_tb.sv

//--- tb/eth_dma_tb.sv
`timescale 1ns/10ps
`default_nettype none

module eth_dma_tb;
   import eth_dma_axi_pkg::*;

   logic        clk_i;
   logic        arst_i;
   logic        tx_en_i;
   logic        rx_en_i;
   logic        host_we_i;
   logic [7:0]  host_addr_i;
   logic [31:0] host_wdata_i;
   axi_ar_t     axi_ar_o;
   logic        axi_arready_i;
   axi_r_t      axi_r_i;
   logic        axi_rready_o;
   axi_aw_t     axi_aw_o;
   logic        axi_awready_i;
   axi_w_t      axi_w_o;
   logic        axi_wready_i;
   logic        axi_bvalid_i;
   logic        axi_bready_o;
   logic        txbuf_wen_o;
   logic [8:0]  txbuf_addr_o;
   logic [31:0] txbuf_wdata_o;
   logic        rxbuf_ren_o;
   logic [8:0]  rxbuf_addr_o;
   logic [31:0] rxbuf_rdata_i;
   logic        crc_err_i;
   logic        crc_en_o;
   logic        tx_irq_o;
   logic        rx_irq_o;

   logic [31:0] lfsr_q;
   logic [31:0] ext_mem [logic [31:0]];
   logic [31:0] txcap [int];
   logic [31:0] rxsrc [512];
   logic [31:0] rd_addr;
   logic [31:0] wr_addr;
   int          rd_left;
   int          wr_left;
   logic        b_pend;
   logic [6:0]  stall;
   int          ar_count;
   int          aw_count;
   int          rx_beats;
   int          irq_count [2];
   int          irq_exp [2];
   int          idx_m [2];

   eth_dma #(.BD_ADDR_W(8), .BUF_ADDR_W(9)) u_dut (.*);

   always #2 clk_i = ~clk_i;

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // Unwritten memory returns a pattern of the full address
   function automatic logic [31:0] ext_rd(input logic [31:0] a);
      if (ext_mem.exists(a)) return ext_mem[a];
      return {a[15:0], a[31:16]} ^ 32'hc3a5_96e1;
   endfunction

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp) begin
         $display("Fail %0t: %s, got %h expected %h", $time, msg, got, exp);
         $display("test failed");
         $fatal(1);
      end
   endtask

   task automatic host_write(input logic [7:0] a, input logic [31:0] d);
      host_we_i    = 1'b1;
      host_addr_i  = a;
      host_wdata_i = d;
      @(posedge clk_i);
      #1;
      host_we_i = 1'b0;
   endtask

   // AXI slaves, MAC buffer models and event counters
   always @(posedge clk_i) begin
      if (!arst_i) begin
         if (axi_ar_o.valid && axi_arready_i) begin
            check_eq(32'(axi_ar_o.len <= 8'd15), 1, "read burst longer than 16");
            rd_addr = axi_ar_o.addr;
            rd_left = axi_ar_o.len + 1;
            ar_count++;
         end else if (axi_r_i.valid) begin
            check_eq(32'(axi_rready_o), 1, "rready low");
            rd_addr = rd_addr + 4;
            rd_left--;
         end
         if (txbuf_wen_o) txcap[txbuf_addr_o] = txbuf_wdata_o;
         if (axi_aw_o.valid && axi_awready_i) begin
            check_eq(32'(axi_aw_o.len <= 8'd15), 1, "write burst longer than 16");
            wr_addr = axi_aw_o.addr;
            wr_left = axi_aw_o.len + 1;
            aw_count++;
         end
         if (axi_w_o.valid && axi_wready_i) begin
            check_eq(32'(wr_left != 0), 1, "write beat before its address");
            check_eq(32'(axi_w_o.last), 32'(wr_left == 1), "wlast position");
            ext_mem[wr_addr] = axi_w_o.data;
            wr_addr = wr_addr + 4;
            wr_left--;
            rx_beats++;
            if (wr_left == 0) b_pend = 1'b1;
         end
         if (axi_bvalid_i) begin
            check_eq(32'(axi_bready_o), 1, "bready low");
            b_pend = 1'b0;
         end
         if (rxbuf_ren_o) rxbuf_rdata_i <= rxsrc[rxbuf_addr_o];
         if (tx_irq_o) irq_count[0]++;
         if (rx_irq_o) irq_count[1]++;
      end
      // Stall bits for arready, awready, wready and bvalid
      stall = 7'(take_bits(7));
      #1;
      axi_arready_i = (rd_left == 0) && (stall[6:5] != 2'b00);
      axi_r_i.valid = (rd_left != 0);
      axi_r_i.data  = ext_rd(rd_addr);
      axi_r_i.last  = (rd_left == 1);
      axi_awready_i = (wr_left == 0) && !b_pend && (stall[4:3] != 2'b00);
      axi_wready_i  = (stall[2:1] != 2'b00);
      axi_bvalid_i  = b_pend && stall[0];
   end

   task automatic run_frame(input bit is_rx, input int f);
      int          len;
      int          idx;
      int          cnt;
      int          tmo;
      logic        irq;
      logic        wrap;
      logic        crc;
      logic [31:0] ptr;
      logic [31:0] ctrl;
      logic [31:0] exp0;
      len  = take_bits(6) % 40 + 1;
      irq  = take_bits(1);
      wrap = (f == 3) || (take_bits(2) == 0);
      crc  = take_bits(1);
      ptr  = 32'h1000_0000 + f * 32'h1000 + (take_bits(8) << 2) + (is_rx ? 32'h10_0000 : 0);
      idx  = idx_m[is_rx];
      ctrl = {16'(len), 1'b0, irq, wrap, 1'b0, is_rx ? 1'b0 : crc, 11'd0};
      txcap.delete();
      rx_beats = 0;
      if (is_rx) begin
         for (int i = 0; i < len; i++) rxsrc[i] = take_bits(32);
         crc_err_i = crc;
      end
      host_write(8'(2 * idx + 1), ptr);
      host_write(8'(2 * idx), ctrl);
      // Without the ready bit the channel must stay quiet
      cnt = is_rx ? aw_count : ar_count;
      repeat (20) @(posedge clk_i);
      #1;
      check_eq(is_rx ? aw_count : ar_count, cnt, "burst issued before ready");
      host_write(8'(2 * idx), ctrl | 32'h8000);
      tmo = 0;
      while (u_dut.u_bd_store.mem[2 * idx][15] !== 1'b0) begin
         @(posedge clk_i);
         #1;
         tmo++;
         if (tmo > 5000) begin
            $display("timeout waiting for descriptor write-back, frame %0d", f);
            $display("test failed");
            $fatal(1);
         end
      end
      repeat (3) @(posedge clk_i);
      #1;
      exp0 = is_rx ? (ctrl | (32'(crc) << 1)) : ctrl;
      check_eq(u_dut.u_bd_store.mem[2 * idx], exp0, "write-back word 0");
      irq_exp[is_rx] = irq_exp[is_rx] + irq;
      check_eq(irq_count[0], irq_exp[0], "transmit interrupt count");
      check_eq(irq_count[1], irq_exp[1], "receive interrupt count");
      idx_m[is_rx] = wrap ? 0 : idx + 1;
      check_eq(is_rx ? u_dut.rx_index : u_dut.tx_index, idx_m[is_rx], "descriptor index");
      if (is_rx) begin
         check_eq(rx_beats, len, "receive beat count");
         for (int i = 0; i < len; i++) check_eq(ext_rd(ptr + 4 * i), rxsrc[i], "memory word");
      end else begin
         check_eq(crc_en_o, crc, "crc_en");
         check_eq(txcap.size(), len, "transmit word count");
         for (int i = 0; i < len; i++) check_eq(txcap[i], ext_rd(ptr + 4 * i), "tx buffer word");
      end
   endtask

   initial begin
      lfsr_q        = 32'h1bbdec48;
      clk_i         = 1'b0;
      arst_i        = 1'b1;
      tx_en_i       = 1'b0;
      rx_en_i       = 1'b0;
      host_we_i     = 1'b0;
      host_addr_i   = '0;
      host_wdata_i  = '0;
      axi_arready_i = 1'b0;
      axi_r_i       = '0;
      axi_awready_i = 1'b0;
      axi_wready_i  = 1'b0;
      axi_bvalid_i  = 1'b0;
      rxbuf_rdata_i = '0;
      crc_err_i     = 1'b0;
      rd_left       = 0;
      wr_left       = 0;
      b_pend        = 1'b0;
      ar_count      = 0;
      aw_count      = 0;
      irq_count     = '{0, 0};
      irq_exp       = '{0, 0};
      idx_m         = '{0, 0};
      repeat (5) @(posedge clk_i);
      #1;
      arst_i = 1'b0;
      for (int a = 0; a < 256; a++) host_write(8'(a), 32'd0);
      tx_en_i = 1'b1;
      for (int f = 0; f < 6; f++) run_frame(1'b0, f);
      tx_en_i = 1'b0;
      @(posedge clk_i);
      #1;
      rx_en_i = 1'b1;
      for (int f = 0; f < 6; f++) run_frame(1'b1, f);
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/eth_dma.sv
`timescale 1ns/10ps
`default_nettype none

module eth_dma #(
   parameter int BD_ADDR_W  = 8,
   parameter int BUF_ADDR_W = 9
) (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  logic                     tx_en_i,
   input  logic                     rx_en_i,
   input  logic                     host_we_i,
   input  logic [BD_ADDR_W-1:0]     host_addr_i,
   input  logic [31:0]              host_wdata_i,
   output eth_dma_axi_pkg::axi_ar_t axi_ar_o,
   input  logic                     axi_arready_i,
   input  eth_dma_axi_pkg::axi_r_t  axi_r_i,
   output logic                     axi_rready_o,
   output eth_dma_axi_pkg::axi_aw_t axi_aw_o,
   input  logic                     axi_awready_i,
   output eth_dma_axi_pkg::axi_w_t  axi_w_o,
   input  logic                     axi_wready_i,
   input  logic                     axi_bvalid_i,
   output logic                     axi_bready_o,
   output logic                     txbuf_wen_o,
   output logic [BUF_ADDR_W-1:0]    txbuf_addr_o,
   output logic [31:0]              txbuf_wdata_o,
   output logic                     rxbuf_ren_o,
   output logic [BUF_ADDR_W-1:0]    rxbuf_addr_o,
   input  logic [31:0]              rxbuf_rdata_i,
   input  logic                     crc_err_i,
   output logic                     crc_en_o,
   output logic                     tx_irq_o,
   output logic                     rx_irq_o
);
   import eth_dma_bd_pkg::*;

   bd_req_t              host_req;
   bd_req_t              stat_req;
   bd_req_t              txf_req;
   bd_req_t              rxf_req;
   logic [3:0]           bd_gnt;
   logic [31:0]          bd_rdata;
   bd_desc_t             tx_desc;
   bd_desc_t             rx_desc;
   logic                 tx_start;
   logic                 rx_start;
   logic                 tx_busy;
   logic                 rx_busy;
   logic                 tx_done;
   logic                 rx_done;
   logic                 rx_crc_err;
   logic [BD_ADDR_W-2:0] tx_index;
   logic [BD_ADDR_W-2:0] rx_index;

   // Host writes only, one word per cycle
   assign host_req = '{en: host_we_i, we: host_we_i, addr: 8'(host_addr_i),
                       wdata: host_wdata_i};

   eth_dma_bd_store #(.BD_ADDR_W(BD_ADDR_W)) u_bd_store (
      .clk_i, .arst_i,
      .host_req_i(host_req), .stat_req_i(stat_req),
      .txf_req_i(txf_req), .rxf_req_i(rxf_req),
      .gnt_o(bd_gnt), .rdata_o(bd_rdata)
   );

   eth_dma_bd_fetch #(.BD_ADDR_W(BD_ADDR_W)) u_tx_fetch (
      .clk_i, .arst_i, .en_i(tx_en_i), .busy_i(tx_busy), .index_i(tx_index),
      .req_o(txf_req), .gnt_i(bd_gnt[2]), .rdata_i(bd_rdata),
      .desc_o(tx_desc), .start_o(tx_start)
   );

   eth_dma_bd_fetch #(.BD_ADDR_W(BD_ADDR_W)) u_rx_fetch (
      .clk_i, .arst_i, .en_i(rx_en_i), .busy_i(rx_busy), .index_i(rx_index),
      .req_o(rxf_req), .gnt_i(bd_gnt[3]), .rdata_i(bd_rdata),
      .desc_o(rx_desc), .start_o(rx_start)
   );

   eth_dma_tx_engine #(.BUF_ADDR_W(BUF_ADDR_W)) u_tx_engine (
      .clk_i, .arst_i, .start_i(tx_start), .desc_i(tx_desc),
      .busy_o(tx_busy), .done_o(tx_done),
      .axi_ar_o, .axi_arready_i, .axi_r_i, .axi_rready_o,
      .txbuf_wen_o, .txbuf_addr_o, .txbuf_wdata_o, .crc_en_o
   );

   eth_dma_rx_engine #(.BUF_ADDR_W(BUF_ADDR_W)) u_rx_engine (
      .clk_i, .arst_i, .start_i(rx_start), .desc_i(rx_desc),
      .busy_o(rx_busy), .done_o(rx_done), .crc_err_o(rx_crc_err),
      .axi_aw_o, .axi_awready_i, .axi_w_o, .axi_wready_i,
      .axi_bvalid_i, .axi_bready_o,
      .rxbuf_ren_o, .rxbuf_addr_o, .rxbuf_rdata_i, .crc_err_i
   );

   eth_dma_status #(.BD_ADDR_W(BD_ADDR_W)) u_status (
      .clk_i, .arst_i,
      .tx_done_i(tx_done), .tx_desc_i(tx_desc),
      .rx_done_i(rx_done), .rx_desc_i(rx_desc), .rx_crc_err_i(rx_crc_err),
      .req_o(stat_req), .gnt_i(bd_gnt[1]),
      .tx_index_o(tx_index), .rx_index_o(rx_index),
      .tx_irq_o, .rx_irq_o
   );

endmodule

`default_nettype wire

//--- verilog/eth_dma_axi_pkg.sv
`default_nettype none

package eth_dma_axi_pkg;

   // Longest burst in words
   localparam int AXI_MAX_BURST = 16;

   typedef struct packed {
      logic        valid;
      logic [31:0] addr;
      logic [7:0]  len;
   } axi_ar_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] addr;
      logic [7:0]  len;
   } axi_aw_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] data;
      logic        last;
   } axi_w_t;

   typedef struct packed {
      logic        valid;
      logic [31:0] data;
      logic        last;
   } axi_r_t;

endpackage

`default_nettype wire

//--- verilog/eth_dma_bd_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module eth_dma_bd_fetch #(
   parameter int BD_ADDR_W = 8
) (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  logic                     en_i,
   input  logic                     busy_i,
   input  logic [BD_ADDR_W-2:0]     index_i,
   output eth_dma_bd_pkg::bd_req_t  req_o,
   input  logic                     gnt_i,
   input  logic [31:0]              rdata_i,
   output eth_dma_bd_pkg::bd_desc_t desc_o,
   output logic                     start_o
);
   import eth_dma_bd_pkg::*;

   typedef enum logic [2:0] {S_IDLE, S_RD0, S_CHK0, S_RD1, S_CHK1, S_GO} state_e;

   state_e      state_q;
   logic        word_sel;
   logic [31:0] ctrl_q;
   logic [31:0] ptr_q;

   // Word 0 at 2n, pointer at 2n+1
   assign word_sel    = (state_q == S_RD1);
   assign req_o.en    = (state_q == S_RD0) || (state_q == S_RD1);
   assign req_o.we    = 1'b0;
   assign req_o.addr  = 8'({index_i, word_sel});
   assign req_o.wdata = '0;

   assign desc_o.ctrl = ctrl_q;
   assign desc_o.ptr  = ptr_q;
   assign start_o     = (state_q == S_GO);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= S_IDLE;
      end else begin
         case (state_q)
            S_IDLE: if (en_i && !busy_i) state_q <= S_RD0;
            S_RD0:  if (gnt_i) state_q <= S_CHK0;
            S_CHK0: begin
               // Keep polling word 0 until the host hands the descriptor over
               if (rdata_i[BD_RDY_BIT]) begin
                  state_q <= S_RD1;
               end else begin
                  state_q <= en_i ? S_RD0 : S_IDLE;
               end
            end
            S_RD1:  if (gnt_i) state_q <= S_CHK1;
            S_CHK1: state_q <= S_GO;
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == S_CHK0) ctrl_q <= rdata_i;
      if (state_q == S_CHK1) ptr_q <= rdata_i;
   end

   assert property (@(posedge clk_i) disable iff (arst_i) start_o |-> !busy_i);

endmodule

`default_nettype wire

//--- verilog/eth_dma_bd_pkg.sv
`default_nettype none

package eth_dma_bd_pkg;

   // Ready (tx) / empty (rx) flag position in control word 0
   localparam int BD_RDY_BIT = 15;

   // Control word as seen by the transmit channel
   typedef struct packed {
      logic [15:0] length;
      logic        ready;
      logic        irq;
      logic        wrap;
      logic        rsvd_12;
      logic        crc_en;
      logic [10:0] rsvd_10_0;
   } bd_ctrl_tx_t;

   // Control word as seen by the receive channel
   typedef struct packed {
      logic [15:0] length;
      logic        empty;
      logic        irq;
      logic        wrap;
      logic [10:0] rsvd_12_2;
      logic        crc_err;
      logic        rsvd_0;
   } bd_ctrl_rx_t;

   typedef union packed {
      bd_ctrl_tx_t tx;
      bd_ctrl_rx_t rx;
   } bd_ctrl_u;

   typedef struct packed {
      bd_ctrl_u    ctrl;
      logic [31:0] ptr;
   } bd_desc_t;

   // One descriptor memory access
   typedef struct packed {
      logic        en;
      logic        we;
      logic [7:0]  addr;
      logic [31:0] wdata;
   } bd_req_t;

endpackage

`default_nettype wire

//--- verilog/eth_dma_bd_store.sv
`timescale 1ns/10ps
`default_nettype none

module eth_dma_bd_store #(
   parameter int BD_ADDR_W = 8
) (
   input  logic                   clk_i,
   input  logic                   arst_i,
   input  eth_dma_bd_pkg::bd_req_t host_req_i,
   input  eth_dma_bd_pkg::bd_req_t stat_req_i,
   input  eth_dma_bd_pkg::bd_req_t txf_req_i,
   input  eth_dma_bd_pkg::bd_req_t rxf_req_i,
   output logic [3:0]             gnt_o,
   output logic [31:0]            rdata_o
);
   import eth_dma_bd_pkg::*;

   logic [31:0] mem [2**BD_ADDR_W];
   bd_req_t     sel;

   // Fixed priority in the order host, status, tx fetch, rx fetch
   always_comb begin
      gnt_o = 4'b0000;
      sel   = host_req_i;
      if (host_req_i.en) begin
         gnt_o[0] = 1'b1;
      end else if (stat_req_i.en) begin
         gnt_o[1] = 1'b1;
         sel      = stat_req_i;
      end else if (txf_req_i.en) begin
         gnt_o[2] = 1'b1;
         sel      = txf_req_i;
      end else if (rxf_req_i.en) begin
         gnt_o[3] = 1'b1;
         sel      = rxf_req_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (sel.en && sel.we) begin
         mem[sel.addr[BD_ADDR_W-1:0]] <= sel.wdata;
      end
      // Read data lands one cycle after the grant
      if (sel.en && !sel.we) begin
         rdata_o <= mem[sel.addr[BD_ADDR_W-1:0]];
      end
   end

   // A requester that loses arbitration keeps its request up
   assert property (@(posedge clk_i) disable iff (arst_i)
      stat_req_i.en && !gnt_o[1] |=> stat_req_i.en);
   assert property (@(posedge clk_i) disable iff (arst_i)
      txf_req_i.en && !gnt_o[2] |=> txf_req_i.en);
   assert property (@(posedge clk_i) disable iff (arst_i)
      rxf_req_i.en && !gnt_o[3] |=> rxf_req_i.en);

endmodule

`default_nettype wire

//--- verilog/eth_dma_rx_engine.sv
`timescale 1ns/10ps
`default_nettype none

module eth_dma_rx_engine #(
   parameter int BUF_ADDR_W = 9
) (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  logic                     start_i,
   input  eth_dma_bd_pkg::bd_desc_t desc_i,
   output logic                     busy_o,
   output logic                     done_o,
   output logic                     crc_err_o,
   output eth_dma_axi_pkg::axi_aw_t axi_aw_o,
   input  logic                     axi_awready_i,
   output eth_dma_axi_pkg::axi_w_t  axi_w_o,
   input  logic                     axi_wready_i,
   input  logic                     axi_bvalid_i,
   output logic                     axi_bready_o,
   output logic                     rxbuf_ren_o,
   output logic [BUF_ADDR_W-1:0]    rxbuf_addr_o,
   input  logic [31:0]              rxbuf_rdata_i,
   input  logic                     crc_err_i
);
   import eth_dma_axi_pkg::*;

   typedef enum logic [2:0] {S_IDLE, S_AW, S_RD, S_WV, S_B, S_DONE} state_e;

   state_e      state_q;
   logic [15:0] len_q;
   logic [31:0] ptr_q;
   logic [15:0] count_q;
   logic [4:0]  beats_q;
   logic        skid_full_q;
   logic [31:0] skid_q;
   logic        crc_q;
   logic [15:0] remain;
   logic [15:0] burst;

   assign remain = len_q - count_q;
   assign burst  = (remain > 16'(AXI_MAX_BURST)) ? 16'(AXI_MAX_BURST) : remain;

   assign busy_o    = (state_q != S_IDLE);
   assign done_o    = (state_q == S_DONE);
   assign crc_err_o = crc_q;

   assign axi_aw_o.valid = (state_q == S_AW);
   assign axi_aw_o.addr  = ptr_q + {14'd0, count_q, 2'b00};
   assign axi_aw_o.len   = 8'(burst - 16'd1);

   // Buffer data arrives the cycle after ren, skid keeps it under back-pressure
   assign axi_w_o.valid = (state_q == S_WV);
   assign axi_w_o.data  = skid_full_q ? skid_q : rxbuf_rdata_i;
   assign axi_w_o.last  = (beats_q == 5'd1);
   assign axi_bready_o  = 1'b1;

   assign rxbuf_ren_o  = (state_q == S_RD);
   assign rxbuf_addr_o = count_q[BUF_ADDR_W-1:0];

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q     <= S_IDLE;
         count_q     <= '0;
         beats_q     <= '0;
         skid_full_q <= 1'b0;
         crc_q       <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (start_i) begin
                  count_q <= '0;
                  state_q <= S_AW;
               end
            end
            S_AW: begin
               if (axi_awready_i) begin
                  beats_q <= 5'(burst);
                  state_q <= S_RD;
               end
            end
            S_RD: state_q <= S_WV;
            S_WV: begin
               if (axi_wready_i) begin
                  skid_full_q <= 1'b0;
                  count_q     <= count_q + 16'd1;
                  beats_q     <= beats_q - 5'd1;
                  state_q     <= axi_w_o.last ? S_B : S_RD;
               end else begin
                  skid_full_q <= 1'b1;
               end
            end
            S_B: begin
               // Next burst only after the response
               if (axi_bvalid_i) begin
                  if (count_q == len_q) begin
                     crc_q   <= crc_err_i;
                     state_q <= S_DONE;
                  end else begin
                     state_q <= S_AW;
                  end
               end
            end
            S_DONE: state_q <= S_IDLE;
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == S_IDLE && start_i) begin
         len_q <= desc_i.ctrl.rx.length;
         ptr_q <= desc_i.ptr;
      end
      if (state_q == S_WV && !axi_wready_i && !skid_full_q) begin
         skid_q <= rxbuf_rdata_i;
      end
   end

endmodule

`default_nettype wire

//--- verilog/eth_dma_status.sv
`timescale 1ns/10ps
`default_nettype none

module eth_dma_status #(
   parameter int BD_ADDR_W = 8
) (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  logic                     tx_done_i,
   input  eth_dma_bd_pkg::bd_desc_t tx_desc_i,
   input  logic                     rx_done_i,
   input  eth_dma_bd_pkg::bd_desc_t rx_desc_i,
   input  logic                     rx_crc_err_i,
   output eth_dma_bd_pkg::bd_req_t  req_o,
   input  logic                     gnt_i,
   output logic [BD_ADDR_W-2:0]     tx_index_o,
   output logic [BD_ADDR_W-2:0]     rx_index_o,
   output logic                     tx_irq_o,
   output logic                     rx_irq_o
);
   import eth_dma_bd_pkg::*;

   logic                 tx_pend_q;
   logic                 rx_pend_q;
   bd_ctrl_u             tx_ctrl_q;
   bd_ctrl_u             rx_ctrl_q;
   bd_ctrl_u             tx_word;
   bd_ctrl_u             rx_word;
   logic                 serve_tx;
   logic [BD_ADDR_W-2:0] wr_index;

   // Write-back values, ready cleared and rx CRC result recorded
   always_comb begin
      tx_word              = tx_desc_i.ctrl;
      tx_word[BD_RDY_BIT]  = 1'b0;
      rx_word              = rx_desc_i.ctrl;
      rx_word[BD_RDY_BIT]  = 1'b0;
      rx_word.rx.crc_err   = rx_crc_err_i;
   end

   // Transmit first when both are pending
   assign serve_tx    = tx_pend_q;
   assign wr_index    = serve_tx ? tx_index_o : rx_index_o;
   assign req_o.en    = tx_pend_q | rx_pend_q;
   assign req_o.we    = 1'b1;
   assign req_o.addr  = 8'({wr_index, 1'b0});
   assign req_o.wdata = serve_tx ? tx_ctrl_q : rx_ctrl_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         tx_pend_q  <= 1'b0;
         rx_pend_q  <= 1'b0;
         tx_index_o <= '0;
         rx_index_o <= '0;
         tx_irq_o   <= 1'b0;
         rx_irq_o   <= 1'b0;
      end else begin
         tx_irq_o <= 1'b0;
         rx_irq_o <= 1'b0;
         if (gnt_i && serve_tx) begin
            tx_pend_q  <= 1'b0;
            tx_irq_o   <= tx_ctrl_q.tx.irq;
            tx_index_o <= tx_ctrl_q.tx.wrap ? '0 : tx_index_o + 1'b1;
         end
         if (gnt_i && !serve_tx) begin
            rx_pend_q  <= 1'b0;
            rx_irq_o   <= rx_ctrl_q.rx.irq;
            rx_index_o <= rx_ctrl_q.rx.wrap ? '0 : rx_index_o + 1'b1;
         end
         if (tx_done_i) tx_pend_q <= 1'b1;
         if (rx_done_i) rx_pend_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (tx_done_i) tx_ctrl_q <= tx_word;
      if (rx_done_i) rx_ctrl_q <= rx_word;
   end

   assert property (@(posedge clk_i) disable iff (arst_i) tx_irq_o |=> !tx_irq_o);
   assert property (@(posedge clk_i) disable iff (arst_i) rx_irq_o |=> !rx_irq_o);

endmodule

`default_nettype wire

//--- verilog/eth_dma_tx_engine.sv
`timescale 1ns/10ps
`default_nettype none

module eth_dma_tx_engine #(
   parameter int BUF_ADDR_W = 9
) (
   input  logic                     clk_i,
   input  logic                     arst_i,
   input  logic                     start_i,
   input  eth_dma_bd_pkg::bd_desc_t desc_i,
   output logic                     busy_o,
   output logic                     done_o,
   output eth_dma_axi_pkg::axi_ar_t axi_ar_o,
   input  logic                     axi_arready_i,
   input  eth_dma_axi_pkg::axi_r_t  axi_r_i,
   output logic                     axi_rready_o,
   output logic                     txbuf_wen_o,
   output logic [BUF_ADDR_W-1:0]    txbuf_addr_o,
   output logic [31:0]              txbuf_wdata_o,
   output logic                     crc_en_o
);
   import eth_dma_axi_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_AR, S_R, S_DONE} state_e;

   state_e      state_q;
   logic [15:0] len_q;
   logic [31:0] ptr_q;
   logic        crc_q;
   logic [15:0] count_q;
   logic [15:0] remain;
   logic [15:0] burst;

   // Words left in the frame, capped at one burst
   assign remain = len_q - count_q;
   assign burst  = (remain > 16'(AXI_MAX_BURST)) ? 16'(AXI_MAX_BURST) : remain;

   assign busy_o         = (state_q != S_IDLE);
   assign done_o         = (state_q == S_DONE);
   assign axi_rready_o   = 1'b1;
   assign axi_ar_o.valid = (state_q == S_AR);
   assign axi_ar_o.addr  = ptr_q + {14'd0, count_q, 2'b00};
   assign axi_ar_o.len   = 8'(burst - 16'd1);

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q     <= S_IDLE;
         count_q     <= '0;
         txbuf_wen_o <= 1'b0;
         crc_en_o    <= 1'b0;
      end else begin
         txbuf_wen_o <= 1'b0;
         case (state_q)
            S_IDLE: begin
               if (start_i) begin
                  count_q <= '0;
                  state_q <= S_AR;
               end
            end
            S_AR: if (axi_arready_i) state_q <= S_R;
            S_R: begin
               if (axi_r_i.valid) begin
                  txbuf_wen_o <= 1'b1;
                  count_q     <= count_q + 16'd1;
                  // End of burst, either another burst or the frame is done
                  if (axi_r_i.last) begin
                     state_q <= (count_q + 16'd1 == len_q) ? S_DONE : S_AR;
                  end
               end
            end
            S_DONE: begin
               crc_en_o <= crc_q;
               state_q  <= S_IDLE;
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == S_IDLE && start_i) begin
         len_q <= desc_i.ctrl.tx.length;
         ptr_q <= desc_i.ptr;
         crc_q <= desc_i.ctrl.tx.crc_en;
      end
      if (state_q == S_R && axi_r_i.valid) begin
         txbuf_addr_o  <= count_q[BUF_ADDR_W-1:0];
         txbuf_wdata_o <= axi_r_i.data;
      end
   end

   assert property (@(posedge clk_i) disable iff (arst_i)
      axi_ar_o.valid |-> axi_ar_o.len <= 8'(AXI_MAX_BURST - 1));

endmodule

`default_nettype wire
